// ==== Bender.yml ====
package:
  name: keypad_display

export_include_dirs:
  - common

sources:
  - common/kpd_pkg.sv
  - keypad/column_scanner.sv
  - keypad/keypad_decoder.sv
  - hdl/display_command_builder.sv
  - screen/lcd_bus_writer.sv
  - hdl/keypad_display_top.sv
  - target: test
    files:
      - tests/keypad_display_tb.sv

// ==== common/kpd_params.svh ====
`ifndef KPD_PARAMS_SVH
`define KPD_PARAMS_SVH

// Clock cycles spent driving each keypad column
`define KPD_SCAN_DIV 1000

// Identical sweeps in a row before a key state is accepted
`define KPD_STABLE_SWEEPS 3

// Screen command bytes
`define LCD_CMD_CURSOR 8'h2A
`define LCD_CMD_WRITE 8'h2C

// Cursor wraps after 2**LCD_CURSOR_BITS characters
`define LCD_CURSOR_BITS 4

`endif

// ==== common/kpd_pkg.sv ====
package kpd_pkg;

    // Key number is column index times four plus row index
    typedef logic [3:0] key_code_t;

    // One key press event as handed from the decoder to the builder
    typedef struct packed {
        key_code_t code;
    } key_event_t;

    // One word on the 8080 screen bus
    // dcx low selects a command byte, dcx high selects a data byte
    typedef struct packed {
        logic       dcx;
        logic [7:0] data;
    } lcd_word_t;

endpackage

// ==== hdl/display_command_builder.sv ====
`timescale 1ns/100ps
`include "kpd_params.svh"

module display_command_builder (
    input  logic                clk,
    input  logic                rst,
    input  logic                key_strobe,
    input  kpd_pkg::key_event_t key,
    input  logic                word_done,
    output logic                word_strobe,
    output kpd_pkg::lcd_word_t  word
);

    logic                             busy;
    logic [1:0]                       step;
    logic [`LCD_CURSOR_BITS-1:0]      cursor;
    kpd_pkg::key_code_t               held_code;

    // ASCII hex digit for a key code
    function automatic logic [7:0] glyph(input kpd_pkg::key_code_t code);
        if (code < 4'd10) begin
            return 8'h30 + 8'(code);
        end
        return 8'h37 + 8'(code);
    endfunction

    always_comb begin
        case (step)
            2'd0: word = '{dcx: 1'b0, data: `LCD_CMD_CURSOR};
            2'd1: word = '{dcx: 1'b1, data: 8'(cursor)};
            2'd2: word = '{dcx: 1'b0, data: `LCD_CMD_WRITE};
            default: word = '{dcx: 1'b1, data: glyph(held_code)};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            step        <= 2'd0;
            cursor      <= '0;
            word_strobe <= 1'b0;
        end else begin
            word_strobe <= 1'b0;
            if (!busy) begin
                // Strobes while busy are simply ignored
                if (key_strobe) begin
                    busy        <= 1'b1;
                    step        <= 2'd0;
                    word_strobe <= 1'b1;
                end
            end else if (word_done) begin
                if (step == 2'd3) begin
                    busy   <= 1'b0;
                    cursor <= cursor + 1'b1;
                end else begin
                    step        <= step + 1'b1;
                    word_strobe <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_strobe && !busy) begin
            held_code <= key.code;
        end
    end

endmodule

// ==== hdl/keypad_display_top.sv ====
`timescale 1ns/100ps
`include "kpd_params.svh"

module keypad_display_top #(
    parameter int scan_div = `KPD_SCAN_DIV
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] row,
    output logic [3:0] column,
    output logic       csx,
    output logic       dcx,
    output logic       wrx,
    output logic [7:0] lcd_data
);

    logic                dwell_end;
    logic                key_strobe;
    kpd_pkg::key_event_t key;
    logic                word_strobe;
    kpd_pkg::lcd_word_t  word;
    logic                word_done;

    column_scanner #(
        .scan_div(scan_div)
    ) scanner0 (
        .clk       (clk),
        .rst       (rst),
        .column    (column),
        .dwell_end (dwell_end)
    );

    keypad_decoder decoder0 (
        .clk        (clk),
        .rst        (rst),
        .column     (column),
        .row        (row),
        .dwell_end  (dwell_end),
        .key_strobe (key_strobe),
        .key        (key)
    );

    display_command_builder builder0 (
        .clk         (clk),
        .rst         (rst),
        .key_strobe  (key_strobe),
        .key         (key),
        .word_done   (word_done),
        .word_strobe (word_strobe),
        .word        (word)
    );

    lcd_bus_writer writer0 (
        .clk         (clk),
        .rst         (rst),
        .word_strobe (word_strobe),
        .word        (word),
        .word_done   (word_done),
        .csx         (csx),
        .dcx         (dcx),
        .wrx         (wrx),
        .lcd_data    (lcd_data)
    );

endmodule

// ==== keypad/column_scanner.sv ====
`timescale 1ns/100ps
`include "kpd_params.svh"

module column_scanner #(
    parameter int scan_div = `KPD_SCAN_DIV
) (
    input  logic       clk,
    input  logic       rst,
    output logic [3:0] column,
    output logic       dwell_end
);

    localparam int cnt_bits = (scan_div > 1) ? $clog2(scan_div) : 1;

    logic [cnt_bits-1:0] dwell_cnt;

    // Last cycle of the current column
    assign dwell_end = (dwell_cnt == cnt_bits'(scan_div - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwell_cnt <= '0;
        end else if (dwell_end) begin
            dwell_cnt <= '0;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // One-hot drive walks 0001 -> 0010 -> 0100 -> 1000
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            column <= 4'b0001;
        end else if (dwell_end) begin
            column <= {column[2:0], column[3]};
        end
    end

endmodule

// ==== keypad/keypad_decoder.sv ====
`timescale 1ns/100ps
`include "kpd_params.svh"

module keypad_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [3:0]             column,
    input  logic [3:0]             row,
    input  logic                   dwell_end,
    output logic                   key_strobe,
    output kpd_pkg::key_event_t    key
);

    localparam int stable_bits = $clog2(`KPD_STABLE_SWEEPS + 1);

    logic [1:0]             col_idx;
    logic [1:0]             row_idx;
    logic                   cand_found;
    kpd_pkg::key_code_t     cand_code;
    logic                   sweep_end;

    // Lowest key seen so far in the running sweep
    logic                   sweep_found;
    kpd_pkg::key_code_t     sweep_min;
    logic                   win_found;
    kpd_pkg::key_code_t     win_code;

    // Winner of the previous sweep and how long it has held
    logic                   prev_found;
    kpd_pkg::key_code_t     prev_code;
    logic [stable_bits-1:0] stable_cnt;
    logic [stable_bits-1:0] stable_next;
    logic                   same;

    logic                   accepted_found;
    kpd_pkg::key_code_t     accepted_code;

    always_comb begin
        case (column)
            4'b0010: col_idx = 2'd1;
            4'b0100: col_idx = 2'd2;
            4'b1000: col_idx = 2'd3;
            default: col_idx = 2'd0;
        endcase
        // Lowest row wins inside one column
        row_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (row[i]) begin
                row_idx = 2'(i);
            end
        end
    end

    assign cand_found = |row;
    assign cand_code  = {col_idx, row_idx};
    assign sweep_end  = dwell_end && column[3];

    assign win_found = sweep_found || cand_found;
    assign win_code  = (sweep_found && (!cand_found || sweep_min < cand_code)) ?
                       sweep_min : cand_code;

    assign same = (win_found == prev_found) && (!win_found || win_code == prev_code);
    assign stable_next = !same ? stable_bits'(1) :
                         (stable_cnt == stable_bits'(`KPD_STABLE_SWEEPS)) ? stable_cnt :
                         stable_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sweep_found    <= 1'b0;
            sweep_min      <= '0;
            prev_found     <= 1'b0;
            prev_code      <= '0;
            stable_cnt     <= '0;
            accepted_found <= 1'b0;
            accepted_code  <= '0;
            key_strobe     <= 1'b0;
        end else begin
            key_strobe <= 1'b0;
            if (sweep_end) begin
                sweep_found <= 1'b0;
                prev_found  <= win_found;
                prev_code   <= win_code;
                stable_cnt  <= stable_next;
                if (stable_next == stable_bits'(`KPD_STABLE_SWEEPS)) begin
                    if (!win_found) begin
                        // Stable release re-arms without an event
                        accepted_found <= 1'b0;
                    end else if (!accepted_found || accepted_code != win_code) begin
                        accepted_found <= 1'b1;
                        accepted_code  <= win_code;
                        key_strobe     <= 1'b1;
                    end
                end
            end else if (dwell_end) begin
                sweep_found <= win_found;
                sweep_min   <= win_code;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_end) begin
            key.code <= win_code;
        end
    end

endmodule

// ==== keypad_display_top.f ====
+incdir+common
common/kpd_pkg.sv
keypad/column_scanner.sv
keypad/keypad_decoder.sv
hdl/display_command_builder.sv
screen/lcd_bus_writer.sv
hdl/keypad_display_top.sv
tests/keypad_display_tb.sv

// ==== screen/lcd_bus_writer.sv ====
`timescale 1ns/100ps

module lcd_bus_writer (
    input  logic               clk,
    input  logic               rst,
    input  logic               word_strobe,
    input  kpd_pkg::lcd_word_t word,
    output logic               word_done,
    output logic               csx,
    output logic               dcx,
    output logic               wrx,
    output logic [7:0]         lcd_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_wr_low,
        st_wr_high
    } wr_state_t;

    wr_state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            csx       <= 1'b1;
            wrx       <= 1'b1;
            dcx       <= 1'b1;
            word_done <= 1'b0;
        end else begin
            word_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (word_strobe) begin
                        csx   <= 1'b0;
                        wrx   <= 1'b0;
                        dcx   <= word.dcx;
                        state <= st_wr_low;
                    end
                end
                st_wr_low: begin
                    // Screen latches on this rising edge
                    wrx   <= 1'b1;
                    state <= st_wr_high;
                end
                st_wr_high: begin
                    csx       <= 1'b1;
                    word_done <= 1'b1;
                    state     <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Data held from the strobe until the next word
    always_ff @(posedge clk) begin
        if (state == st_idle && word_strobe) begin
            lcd_data <= word.data;
        end
    end

endmodule

// ==== tests/keypad_display_tb.sv ====
`timescale 1ns/100ps
`include "kpd_params.svh"

module keypad_display_tb;

    localparam int scan_div = 8;
    localparam int sweep_cycles = 4 * scan_div;
    localparam int settle_sweeps = `KPD_STABLE_SWEEPS + 2;
    localparam int num_tests = 6;
    // Longest test presses and releases seventeen keys
    localparam int sweeps_per_test = 17 * 2 * (settle_sweeps + 1);
    localparam longint watchdog_ns = 2 * num_tests * sweeps_per_test * sweep_cycles * 20;
    localparam int word_timeout = (settle_sweeps + 1) * sweep_cycles + 64;

    logic       clk;
    logic       rst;
    logic [3:0] row;
    logic [3:0] column;
    logic       csx;
    logic       dcx;
    logic       wrx;
    logic [7:0] lcd_data;

    logic       held_valid;
    logic [3:0] held_code;

    kpd_pkg::lcd_word_t words[$];
    int value_errors;
    int other_errors;

    always #10 clk = ~clk;

    // Held key sits in column code[3:2] and row code[1:0]
    assign row = (held_valid && column[held_code[3:2]]) ? (4'b0001 << held_code[1:0]) : 4'b0000;

    keypad_display_top #(
        .scan_div(scan_div)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .row      (row),
        .column   (column),
        .csx      (csx),
        .dcx      (dcx),
        .wrx      (wrx),
        .lcd_data (lcd_data)
    );

    // Screen latches on the rising write strobe
    always @(posedge wrx) begin
        if (csx === 1'b0) begin
            words.push_back('{dcx: dcx, data: lcd_data});
        end
    end

    function automatic logic [7:0] ascii_hex(input logic [3:0] code);
        if (code <= 4'd9) begin
            return 8'h30 + code;
        end
        return 8'h41 + code - 4'd10;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: %s expected %0h actual %0h", test, what, expected, actual);
        end
    endtask

    // Inputs change just after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst = 1'b1;
        held_valid = 1'b0;
        step_cycles(3);
        rst = 1'b0;
        words.delete();
    endtask

    task automatic set_key(input logic valid, input logic [3:0] code);
        held_valid = valid;
        held_code = code;
    endtask

    task automatic wait_words(input string test, input int count, output bit ok);
        int waited;
        waited = 0;
        while (words.size() < count && waited < word_timeout) begin
            step_cycles(1);
            waited++;
        end
        ok = (words.size() >= count);
        if (!ok) begin
            other_errors++;
            $display("%s: only %0d of %0d screen words arrived in time",
                     test, words.size(), count);
        end
    endtask

    // Cursor command, cursor, write command, glyph
    task automatic expect_sequence(input string test, input int cursor, input logic [3:0] code);
        bit ok;
        kpd_pkg::lcd_word_t w;
        wait_words(test, 4, ok);
        if (ok) begin
            w = words.pop_front();
            check_value(test, "cursor command", {1'b0, `LCD_CMD_CURSOR}, w);
            w = words.pop_front();
            check_value(test, "cursor data", {1'b1, 8'(cursor)}, w);
            w = words.pop_front();
            check_value(test, "write command", {1'b0, `LCD_CMD_WRITE}, w);
            w = words.pop_front();
            check_value(test, "glyph data", {1'b1, ascii_hex(code)}, w);
        end
    endtask

    task automatic observe_reset_state();
        apply_reset();
        check_value("reset_state", "csx", 1'b1, csx);
        check_value("reset_state", "wrx", 1'b1, wrx);
        check_value("reset_state", "column", 4'b0001, column);
        step_cycles(5 * sweep_cycles);
        check_value("reset_state", "captured words", 0, words.size());
    endtask

    task automatic observe_column_rotation();
        logic [3:0] expected;
        int cnt;
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            expected = 4'b0001 << (i % 4);
            check_value("column_rotation", "column", expected, column);
            cnt = 0;
            while (column == expected && cnt < sweep_cycles) begin
                step_cycles(1);
                cnt++;
            end
            check_value("column_rotation", "dwell cycles", scan_div, cnt);
        end
    endtask

    task automatic press_single_key();
        apply_reset();
        set_key(1'b1, 4'd5);
        expect_sequence("single_press", 0, 4'd5);
        set_key(1'b0, 4'd0);
        step_cycles(settle_sweeps * sweep_cycles);
        check_value("single_press", "extra words", 0, words.size());
    endtask

    task automatic hold_and_repress();
        apply_reset();
        set_key(1'b1, 4'hB);
        step_cycles(12 * sweep_cycles);
        check_value("hold_repress", "words after long hold", 4, words.size());
        expect_sequence("hold_repress", 0, 4'hB);
        set_key(1'b0, 4'd0);
        step_cycles(settle_sweeps * sweep_cycles);
        set_key(1'b1, 4'hB);
        expect_sequence("hold_repress", 1, 4'hB);
        set_key(1'b0, 4'd0);
        step_cycles(settle_sweeps * sweep_cycles);
        check_value("hold_repress", "extra words", 0, words.size());
    endtask

    task automatic wrap_cursor_random_keys();
        logic [3:0] code;
        apply_reset();
        for (int i = 0; i < 17; i++) begin
            code = 4'($urandom);
            set_key(1'b1, code);
            expect_sequence("cursor_wrap", i % (1 << `LCD_CURSOR_BITS), code);
            set_key(1'b0, 4'd0);
            step_cycles(settle_sweeps * sweep_cycles);
        end
        check_value("cursor_wrap", "extra words", 0, words.size());
    endtask

    task automatic reject_bounce();
        apply_reset();
        // Seen in one sweep fewer than needed
        set_key(1'b1, 4'h3);
        step_cycles((`KPD_STABLE_SWEEPS - 1) * sweep_cycles);
        set_key(1'b0, 4'd0);
        step_cycles((settle_sweeps + 1) * sweep_cycles);
        check_value("bounce", "words after short press", 0, words.size());
        // Decoder still takes a proper press
        set_key(1'b1, 4'h3);
        expect_sequence("bounce", 0, 4'h3);
        set_key(1'b0, 4'd0);
        step_cycles(settle_sweeps * sweep_cycles);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        held_valid = 1'b0;
        held_code = 4'd0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'h6bb1_78c7));

        observe_reset_state();
        observe_column_rotation();
        press_single_key();
        hold_and_repress();
        wrap_cursor_random_keys();
        reject_bounce();

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule
